// ==== filelist.f ====
source/gomoku_pkg.sv
source/host_regs.sv
source/scan_counter.sv
source/line_checker.sv
source/kill_fsm.sv
source/kill_top.sv
testbench/kill_properties.sv
testbench/kill_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the gomoku evaluator testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module kill_tb -f filelist.f -o kill_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/kill_sim +verilator+error+limit+100 > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "run complete"
exit 0

// ==== source/gomoku_pkg.sv ====
// shared types for the gomoku evaluator; coord_t is 4 bits, so boards are limited to 15x15
package gomoku_pkg;

    // one square of the board
    typedef logic [1:0] cell_t;
    // row or column index
    typedef logic [3:0] coord_t;
    // evaluation outcome
    typedef logic [1:0] result_t;
    // wishbone word address and data
    typedef logic [8:0] wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_BLACK = 2'd1;
    localparam cell_t CELL_WHITE = 2'd2;

    localparam result_t RES_NONE  = 2'd0;
    localparam result_t RES_WIN   = 2'd1;
    localparam result_t RES_BLOCK = 2'd2;
    localparam result_t RES_LOST  = 2'd3;

    // stones in a row for a win, overlines are not treated specially
    localparam int WIN_LEN = 5;

    // register map above the board cells
    localparam wb_adr_t ADR_CTRL   = 9'h100;
    localparam wb_adr_t ADR_STATUS = 9'h101;

    // master side of a wishbone classic bus
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

endpackage

// ==== source/host_regs.sv ====
// wishbone classic slave; ack one cycle after request, cell writes and starts ignored while busy
`timescale 1ns/1ps

module host_regs #(
    parameter int BOARD_N = 9
) (
    input  logic                                     i_clk,
    input  logic                                     i_rst_n,
    input  gomoku_pkg::wb_req_t                      i_wb,
    input  logic                                     i_busy,
    input  logic                                     i_done,
    input  gomoku_pkg::result_t                      i_result,
    input  gomoku_pkg::coord_t                       i_res_row,
    input  gomoku_pkg::coord_t                       i_res_col,
    output gomoku_pkg::wb_rsp_t                      o_wb,
    output logic                                     o_start,
    output gomoku_pkg::cell_t                        o_side,
    output gomoku_pkg::cell_t [BOARD_N*BOARD_N-1:0]  o_board
);

    localparam gomoku_pkg::wb_adr_t CELL_LIMIT = gomoku_pkg::wb_adr_t'(BOARD_N * BOARD_N);

    gomoku_pkg::cell_t [BOARD_N*BOARD_N-1:0] board_q;
    gomoku_pkg::cell_t                        side_q;
    gomoku_pkg::result_t                      result_q;
    gomoku_pkg::coord_t                       row_q;
    gomoku_pkg::coord_t                       col_q;
    gomoku_pkg::wb_dat_t                      rdat_q;
    gomoku_pkg::wb_dat_t                      rdat_d;
    logic                                     ack_q;
    logic                                     start_q;
    logic                                     done_q;
    logic                                     req_fire;
    logic                                     is_cell;
    logic                                     start_req;

    // a new request is one that has not been acked yet
    assign req_fire  = i_wb.cyc & i_wb.stb & ~ack_q;
    assign is_cell   = i_wb.adr < CELL_LIMIT;
    // start_q covers the cycle before the engine reports busy
    assign start_req = req_fire & i_wb.we & (i_wb.adr == gomoku_pkg::ADR_CTRL)
                     & i_wb.dat[0] & ~i_busy & ~start_q;

    // read mux
    always_comb begin
        rdat_d = '0;
        if (is_cell) begin
            rdat_d[1:0] = board_q[i_wb.adr];
        end else if (i_wb.adr == gomoku_pkg::ADR_STATUS) begin
            rdat_d = {4'd0, row_q, col_q, result_q, done_q, i_busy};
        end
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_q    <= 1'b0;
            rdat_q   <= '0;
            start_q  <= 1'b0;
            side_q   <= gomoku_pkg::CELL_BLACK;
            board_q  <= '0;
            done_q   <= 1'b0;
            result_q <= gomoku_pkg::RES_NONE;
            row_q    <= '0;
            col_q    <= '0;
        end else begin
            ack_q   <= req_fire;
            start_q <= start_req;
            if (req_fire) begin
                rdat_q <= rdat_d;
            end
            // board is frozen during an evaluation
            if (req_fire && i_wb.we && is_cell && !i_busy) begin
                board_q[i_wb.adr] <= i_wb.dat[1:0];
            end
            if (start_req) begin
                side_q <= i_wb.dat[1] ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q   <= 1'b1;
                result_q <= i_result;
                row_q    <= i_res_row;
                col_q    <= i_res_col;
            end
        end
    end

    assign o_wb.ack = ack_q;
    assign o_wb.dat = rdat_q;
    assign o_start  = start_q;
    assign o_side   = side_q;
    assign o_board  = board_q;

endmodule

// ==== source/kill_fsm.sv ====
// one-ply evaluation FSM; own scan stops at the first hit, opponent scan always covers the board
`timescale 1ns/1ps

module kill_fsm (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  gomoku_pkg::cell_t   i_side,
    input  logic                i_five,
    input  logic                i_last,
    input  gomoku_pkg::coord_t  i_row,
    input  gomoku_pkg::coord_t  i_col,
    output logic                o_clear,
    output logic                o_step,
    output gomoku_pkg::cell_t   o_color,
    output logic                o_busy,
    output logic                o_done,
    output gomoku_pkg::result_t o_result,
    output gomoku_pkg::coord_t  o_res_row,
    output gomoku_pkg::coord_t  o_res_col
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN_OWN,
        SCAN_OPP,
        FINISH
    } state_t;

    state_t              state_q;
    logic                busy_q;
    logic                done_q;
    gomoku_pkg::result_t result_q;
    gomoku_pkg::coord_t  row_q;
    gomoku_pkg::coord_t  col_q;
    logic [1:0]          hits_q;
    logic [1:0]          hits_d;
    gomoku_pkg::cell_t   opp_color;
    gomoku_pkg::result_t opp_result;

    assign opp_color = (i_side == gomoku_pkg::CELL_BLACK) ? gomoku_pkg::CELL_WHITE
                                                          : gomoku_pkg::CELL_BLACK;

    // saturating threat count, two already means lost
    always_comb begin
        hits_d = (i_five && hits_q != 2'd2) ? hits_q + 2'd1 : hits_q;
        case (hits_d)
            2'd0:    opp_result = gomoku_pkg::RES_NONE;
            2'd1:    opp_result = gomoku_pkg::RES_BLOCK;
            default: opp_result = gomoku_pkg::RES_LOST;
        endcase
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= IDLE;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            result_q <= gomoku_pkg::RES_NONE;
            row_q    <= '0;
            col_q    <= '0;
            hits_q   <= '0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (i_start) begin
                        state_q  <= SCAN_OWN;
                        busy_q   <= 1'b1;
                        result_q <= gomoku_pkg::RES_NONE;
                        row_q    <= '0;
                        col_q    <= '0;
                        hits_q   <= '0;
                    end
                end
                SCAN_OWN: begin
                    if (i_five) begin
                        result_q <= gomoku_pkg::RES_WIN;
                        row_q    <= i_row;
                        col_q    <= i_col;
                        done_q   <= 1'b1;
                        state_q  <= FINISH;
                    end else if (i_last) begin
                        // counter wraps to square 0 on its own
                        state_q <= SCAN_OPP;
                    end
                end
                SCAN_OPP: begin
                    hits_q <= hits_d;
                    if (i_five && hits_q == 2'd0) begin
                        row_q <= i_row;
                        col_q <= i_col;
                    end
                    if (i_last) begin
                        result_q <= opp_result;
                        done_q   <= 1'b1;
                        state_q  <= FINISH;
                    end
                end
                FINISH: begin
                    busy_q  <= 1'b0;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // counter held at square 0 between evaluations
    assign o_clear   = (state_q == IDLE);
    assign o_step    = (state_q == SCAN_OWN) || (state_q == SCAN_OPP);
    assign o_color   = (state_q == SCAN_OPP) ? opp_color : i_side;
    assign o_busy    = busy_q;
    assign o_done    = done_q;
    assign o_result  = result_q;
    assign o_res_row = row_q;
    assign o_res_col = col_q;

endmodule

// ==== source/kill_top.sv ====
// gomoku threat evaluator top; BOARD_N must lie between 5 and 15
`timescale 1ns/1ps

module kill_top #(
    parameter int BOARD_N = 9
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  gomoku_pkg::wb_req_t i_wb,
    output gomoku_pkg::wb_rsp_t o_wb
);

    gomoku_pkg::cell_t [BOARD_N*BOARD_N-1:0] board;
    gomoku_pkg::cell_t                        side;
    gomoku_pkg::cell_t                        color;
    gomoku_pkg::coord_t                       row;
    gomoku_pkg::coord_t                       col;
    gomoku_pkg::coord_t                       res_row;
    gomoku_pkg::coord_t                       res_col;
    gomoku_pkg::result_t                      result;
    logic                                     start;
    logic                                     busy;
    logic                                     done;
    logic                                     clear;
    logic                                     step;
    logic                                     last;
    logic                                     five;

    host_regs #(.BOARD_N(BOARD_N)) u_regs (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb(i_wb),
        .i_busy(busy), .i_done(done), .i_result(result),
        .i_res_row(res_row), .i_res_col(res_col),
        .o_wb(o_wb), .o_start(start), .o_side(side), .o_board(board)
    );

    scan_counter #(.BOARD_N(BOARD_N)) u_counter (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(clear), .i_step(step),
        .o_row(row), .o_col(col), .o_last(last)
    );

    line_checker #(.BOARD_N(BOARD_N)) u_checker (
        .i_board(board), .i_row(row), .i_col(col), .i_color(color), .o_five(five)
    );

    kill_fsm u_fsm (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(start), .i_side(side),
        .i_five(five), .i_last(last), .i_row(row), .i_col(col),
        .o_clear(clear), .o_step(step), .o_color(color), .o_busy(busy),
        .o_done(done), .o_result(result), .o_res_row(res_row), .o_res_col(res_col)
    );

endmodule

// ==== source/line_checker.sv ====
// combinational five-in-a-row test on one square; longer lines also count as five
`timescale 1ns/1ps

module line_checker #(
    parameter int BOARD_N = 9
) (
    input  gomoku_pkg::cell_t [BOARD_N*BOARD_N-1:0] i_board,
    input  gomoku_pkg::coord_t                      i_row,
    input  gomoku_pkg::coord_t                      i_col,
    input  gomoku_pkg::cell_t                       i_color,
    output logic                                    o_five
);

    localparam int CELLS = BOARD_N * BOARD_N;
    // horizontal, vertical, diagonal, anti-diagonal
    localparam int DR[4] = '{0, 1, 1, 1};
    localparam int DC[4] = '{1, 0, 1, -1};

    // stones of one colour walking away from the square, stops at the edge
    function automatic int run_len(input gomoku_pkg::cell_t [CELLS-1:0] board,
                                   input int row, input int col,
                                   input int dr, input int dc,
                                   input gomoku_pkg::cell_t color);
        int   count;
        int   r;
        int   c;
        logic alive;
        count = 0;
        alive = 1'b1;
        for (int k = 1; k < gomoku_pkg::WIN_LEN; k++) begin
            r = row + k * dr;
            c = col + k * dc;
            if (r < 0 || r >= BOARD_N || c < 0 || c >= BOARD_N) begin
                alive = 1'b0;
            end else if (alive && board[r * BOARD_N + c] == color) begin
                count = count + 1;
            end else begin
                alive = 1'b0;
            end
        end
        return count;
    endfunction

    always_comb begin
        int   total;
        logic hit;
        hit = 1'b0;
        for (int d = 0; d < 4; d++) begin
            total = run_len(i_board, int'(i_row), int'(i_col), DR[d], DC[d], i_color)
                  + run_len(i_board, int'(i_row), int'(i_col), -DR[d], -DC[d], i_color);
            if (total >= gomoku_pkg::WIN_LEN - 1) begin
                hit = 1'b1;
            end
        end
        // only an empty square can be played
        o_five = hit && (i_board[int'(i_row) * BOARD_N + int'(i_col)] == gomoku_pkg::CELL_EMPTY);
    end

endmodule

// ==== source/scan_counter.sv ====
// row-major square counter; wraps to zero after the last square, BOARD_N up to 15
`timescale 1ns/1ps

module scan_counter #(
    parameter int BOARD_N = 9
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_clear,
    input  logic               i_step,
    output gomoku_pkg::coord_t o_row,
    output gomoku_pkg::coord_t o_col,
    output logic               o_last
);

    localparam gomoku_pkg::coord_t LAST_IDX = gomoku_pkg::coord_t'(BOARD_N - 1);

    gomoku_pkg::coord_t row_q;
    gomoku_pkg::coord_t col_q;

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_q <= '0;
            col_q <= '0;
        end else if (i_clear) begin
            row_q <= '0;
            col_q <= '0;
        end else if (i_step) begin
            if (col_q == LAST_IDX) begin
                col_q <= '0;
                // last row wraps back to the top
                row_q <= (row_q == LAST_IDX) ? '0 : row_q + 4'd1;
            end else begin
                col_q <= col_q + 4'd1;
            end
        end
    end

    assign o_row  = row_q;
    assign o_col  = col_q;
    assign o_last = (row_q == LAST_IDX) && (col_q == LAST_IDX);

endmodule

// ==== testbench/kill_properties.sv ====
// wishbone checks bound into kill_top; fail_cnt counts failed assertions for the testbench
`timescale 1ns/1ps

module kill_properties #(
    parameter int BOARD_N = 9
) (
    input logic                i_clk,
    input logic                i_rst_n,
    input gomoku_pkg::wb_req_t i_wb,
    input gomoku_pkg::wb_rsp_t i_rsp
);

    int unsigned fail_cnt = 0;
    logic        unmapped;

    // control register reads back zero as well
    assign unmapped = (i_wb.adr >= gomoku_pkg::wb_adr_t'(BOARD_N * BOARD_N))
                   && (i_wb.adr != gomoku_pkg::ADR_STATUS);

    ack_needs_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rsp.ack |-> (i_wb.cyc && i_wb.stb))
    else begin
        fail_cnt++;
        $error("ack raised without an active request");
    end

    ack_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_rsp.ack && $past(i_rsp.ack)))
    else begin
        fail_cnt++;
        $error("ack held high for two cycles");
    end

    unmapped_reads_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rsp.ack && !i_wb.we && unmapped) |-> (i_rsp.dat == '0))
    else begin
        fail_cnt++;
        $error("nonzero read data from an unmapped address");
    end

endmodule

bind kill_top kill_properties #(.BOARD_N(BOARD_N)) u_props (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb(i_wb), .i_rsp(o_wb)
);

// ==== testbench/kill_tb.sv ====
// 9x9 board only; bus accesses are single classic cycles and the bound checks need kill_properties
`timescale 1ns/1ps

module kill_tb;

    localparam int BOARD_N    = 9;
    localparam int CELLS      = BOARD_N * BOARD_N;
    localparam int CLK_NS     = 8;
    localparam int ACK_LIMIT  = 16;
    localparam int DONE_LIMIT = 2 * CELLS + 20;

    logic                clk;
    logic                rst_n;
    gomoku_pkg::wb_req_t wb_req;
    gomoku_pkg::wb_rsp_t wb_rsp;
    gomoku_pkg::wb_dat_t rd_data;
    gomoku_pkg::cell_t   board_m [CELLS];
    int                  seed;

    kill_top #(.BOARD_N(BOARD_N)) i_dut (
        .i_clk(clk), .i_rst_n(rst_n), .i_wb(wb_req), .o_wb(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input int exp, input int got);
        assert (exp == got) else begin
            abort_run($sformatf("Mismatch at %0t: %s expected %0h got %0h",
                                $time, name, exp, got));
        end
    endtask

    // one classic cycle that ends on a falling edge with the bus released
    task automatic bus_cycle(input logic we, input gomoku_pkg::wb_adr_t adr,
                             input gomoku_pkg::wb_dat_t dat);
        int waited;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        waited = 0;
        @(negedge clk);
        while (!wb_rsp.ack) begin
            waited++;
            if (waited > ACK_LIMIT) begin
                abort_run($sformatf("no ack from the slave for address %0h", adr));
            end
            @(negedge clk);
        end
        rd_data = wb_rsp.dat;
        // stb drops after the rising edge that takes the ack
        @(negedge clk);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    // up to four own-colour stones walking away from (r,c)
    function automatic int side_run(input int r, input int c, input int dr, input int dc,
                                    input gomoku_pkg::cell_t color);
        int n;
        n = 0;
        r = r + dr;
        c = c + dc;
        while (n < gomoku_pkg::WIN_LEN - 1 && r >= 0 && r < BOARD_N && c >= 0
               && c < BOARD_N && board_m[r * BOARD_N + c] == color) begin
            n++;
            r = r + dr;
            c = c + dc;
        end
        return n;
    endfunction

    // longest line through (r,c) if a stone of this colour stood there
    function automatic int longest_line(input int r, input int c,
                                        input gomoku_pkg::cell_t color);
        int best;
        int len;
        best = 0;
        for (int dr = 0; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                len = 1 + side_run(r, c, dr, dc, color) + side_run(r, c, -dr, -dc, color);
                if ((dr == 1 || dc == 1) && len > best) begin
                    best = len;
                end
            end
        end
        return best;
    endfunction

    function automatic logic makes_five(input int idx, input gomoku_pkg::cell_t color);
        return board_m[idx] == gomoku_pkg::CELL_EMPTY
            && longest_line(idx / BOARD_N, idx % BOARD_N, color) >= gomoku_pkg::WIN_LEN;
    endfunction

    function automatic logic any_five(input gomoku_pkg::cell_t color);
        logic found;
        found = 1'b0;
        for (int i = 0; i < CELLS; i++) begin
            found = found | makes_five(i, color);
        end
        return found;
    endfunction

    // status word after done with the first hit in row-major order
    function automatic int expected_status(input gomoku_pkg::cell_t side);
        gomoku_pkg::cell_t   opp;
        gomoku_pkg::result_t res;
        int                  hits;
        int                  pos;
        opp  = (side == gomoku_pkg::CELL_BLACK) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
        res  = gomoku_pkg::RES_NONE;
        hits = 0;
        pos  = 0;
        for (int i = 0; i < CELLS && res != gomoku_pkg::RES_WIN; i++) begin
            if (makes_five(i, side)) begin
                res = gomoku_pkg::RES_WIN;
                pos = i;
            end
        end
        if (res != gomoku_pkg::RES_WIN) begin
            for (int i = 0; i < CELLS; i++) begin
                if (makes_five(i, opp)) begin
                    pos  = (hits == 0) ? i : pos;
                    hits = hits + 1;
                end
            end
            res = (hits == 0) ? gomoku_pkg::RES_NONE
                : (hits == 1) ? gomoku_pkg::RES_BLOCK : gomoku_pkg::RES_LOST;
        end
        return ((pos / BOARD_N) << 8) | ((pos % BOARD_N) << 4) | (int'(res) << 2) | 2;
    endfunction

    task automatic clear_board();
        for (int i = 0; i < CELLS; i++) begin
            board_m[i] = gomoku_pkg::CELL_EMPTY;
        end
    endtask

    task automatic load_board();
        for (int i = 0; i < CELLS; i++) begin
            bus_cycle(1'b1, gomoku_pkg::wb_adr_t'(i), gomoku_pkg::wb_dat_t'(board_m[i]));
        end
        for (int i = 0; i < CELLS; i++) begin
            bus_cycle(1'b0, gomoku_pkg::wb_adr_t'(i), '0);
            check_value($sformatf("cell[%0d]", i), int'(board_m[i]), int'(rd_data));
        end
    endtask

    // scattered stones with no line above three and no square that makes five
    task automatic build_quiet_board();
        int                idx;
        gomoku_pkg::cell_t color;
        clear_board();
        for (int k = 0; k < 40; k++) begin
            idx   = $unsigned($random(seed)) % CELLS;
            color = ($random(seed) & 1) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
            if (board_m[idx] == gomoku_pkg::CELL_EMPTY) begin
                board_m[idx] = color;
                if (longest_line(idx / BOARD_N, idx % BOARD_N, color) > 3
                    || any_five(gomoku_pkg::CELL_BLACK) || any_five(gomoku_pkg::CELL_WHITE)) begin
                    board_m[idx] = gomoku_pkg::CELL_EMPTY;
                end
            end
        end
    endtask

    task automatic wait_done();
        time t0;
        t0 = $time;
        bus_cycle(1'b0, gomoku_pkg::ADR_STATUS, '0);
        while (rd_data[1:0] != 2'b10) begin
            if ($time - t0 > DONE_LIMIT * CLK_NS) begin
                abort_run("evaluation did not finish before the timeout");
            end
            bus_cycle(1'b0, gomoku_pkg::ADR_STATUS, '0);
        end
    endtask

    task automatic run_eval(input gomoku_pkg::cell_t side);
        bus_cycle(1'b1, gomoku_pkg::ADR_CTRL, {14'd0, side == gomoku_pkg::CELL_WHITE, 1'b1});
        wait_done();
        check_value("status", expected_status(side), int'(rd_data));
    endtask

    always @(negedge clk) begin
        if (i_dut.u_props.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end
    end

    initial begin
        gomoku_pkg::cell_t flip;
        seed   = 32'h5d86;
        rst_n  = 1'b0;
        wb_req = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        bus_cycle(1'b0, gomoku_pkg::ADR_STATUS, '0);
        check_value("status", 0, int'(rd_data));
        for (int i = 0; i < CELLS; i++) begin
            bus_cycle(1'b0, gomoku_pkg::wb_adr_t'(i), '0);
            check_value($sformatf("cell[%0d]", i), 0, int'(rd_data));
        end
        bus_cycle(1'b0, 9'h0ff, '0);
        bus_cycle(1'b0, 9'h1ff, '0);

        // white four ending at the right edge
        clear_board();
        for (int c = 5; c < BOARD_N; c++) begin
            board_m[2 * BOARD_N + c] = gomoku_pkg::CELL_WHITE;
        end
        load_board();
        run_eval(gomoku_pkg::CELL_WHITE);

        // black diagonal whose first completion is the corner
        clear_board();
        for (int k = 1; k <= 4; k++) begin
            board_m[k * BOARD_N + k] = gomoku_pkg::CELL_BLACK;
        end
        load_board();
        run_eval(gomoku_pkg::CELL_BLACK);

        // white four capped on the left leaves one block square
        clear_board();
        board_m[6 * BOARD_N] = gomoku_pkg::CELL_BLACK;
        for (int c = 1; c <= 4; c++) begin
            board_m[6 * BOARD_N + c] = gomoku_pkg::CELL_WHITE;
        end
        load_board();
        run_eval(gomoku_pkg::CELL_BLACK);

        // cell write and restart as white during an evaluation
        // white to move would turn this board into a win
        flip = (board_m[40] == gomoku_pkg::CELL_WHITE) ? gomoku_pkg::CELL_BLACK
                                                       : gomoku_pkg::CELL_WHITE;
        bus_cycle(1'b1, gomoku_pkg::ADR_CTRL, 16'h0001);
        bus_cycle(1'b0, gomoku_pkg::ADR_STATUS, '0);
        check_value("status.busy", 1, int'(rd_data[0]));
        bus_cycle(1'b1, 9'd40, gomoku_pkg::wb_dat_t'(flip));
        bus_cycle(1'b1, gomoku_pkg::ADR_CTRL, 16'h0003);
        wait_done();
        check_value("status", expected_status(gomoku_pkg::CELL_BLACK), int'(rd_data));
        bus_cycle(1'b0, 9'd40, '0);
        check_value("cell[40]", int'(board_m[40]), int'(rd_data));

        // open white four
        clear_board();
        for (int c = 2; c <= 5; c++) begin
            board_m[4 * BOARD_N + c] = gomoku_pkg::CELL_WHITE;
        end
        load_board();
        run_eval(gomoku_pkg::CELL_BLACK);

        build_quiet_board();
        load_board();
        run_eval(gomoku_pkg::CELL_BLACK);

        if (i_dut.u_props.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("a bound protocol assertion failed");
        end
    end

endmodule
